//--- all.f
design/vldu_pkg.sv
design/vldu_if.sv
design/vinsn_queue.sv
design/beat_unpacker.sv
design/result_queue.sv
design/vldu_top.sv
test/tb_clock.sv
test/vldu_properties.sv
test/vldu_tb.sv

//--- Makefile
SRCS := $(shell cat all.f)

.PHONY: run clean

# Running returns the simulator's exit status, nonzero on any fatal
run: obj_dir/Vvldu_tb
	./obj_dir/Vvldu_tb

obj_dir/Vvldu_tb: all.f $(SRCS)
	verilator --binary --timing --assert --top-module vldu_tb -f all.f -o Vvldu_tb

clean:
	rm -rf obj_dir

//--- test/vldu_tb.sv
`default_nettype none

module vldu_tb import vldu_pkg::*; ();

  localparam int NrLanes      = 2;
  localparam int AxiDataWidth = 64;
  localparam int BeatBytes    = AxiDataWidth / 8;
  localparam int WordBytes    = 8 * NrLanes;
  localparam int NumRows      = 10;
  // Last four rows get their bursts only once all four are queued
  localparam int StallFrom    = NumRows - 4;
  localparam int MaxBytes     = 256;
  localparam int Timeout      = 2000;
  localparam logic [31:0] Seed = 32'hfed3db5b;

  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vlen_t vl;
    vsew_e vsew;
    int    gnt_pct;
  } row_t;

  logic                        clk;
  logic                        rst_n;
  logic                        req_valid;
  logic                        req_ready;
  vid_t                        req_id;
  vreg_t                       req_vd;
  vlen_t                       req_vl;
  vsew_e                       req_vsew;
  logic                        ar_valid;
  beat_len_t                   ar_len;
  logic                        ar_ready;
  logic                        r_valid;
  logic [AxiDataWidth-1:0]     r_data;
  logic                        r_ready;
  logic   [NrLanes-1:0]        result_req;
  vid_t   [NrLanes-1:0]        result_id;
  vaddr_t [NrLanes-1:0]        result_addr;
  elen_t  [NrLanes-1:0]        result_wdata;
  strb_t  [NrLanes-1:0]        result_be;
  logic   [NrLanes-1:0]        result_gnt;
  logic                        done_valid;
  vid_t                        done_id;

  // Stimulus table and generated load bytes
  row_t       rows       [NumRows];
  logic [7:0] insn_bytes [NumRows][MaxBytes];
  logic       stall_release;

  // Expected lane writes with one entry per register-file word
  elen_t [NrLanes-1:0] exp_wdata [$];
  strb_t [NrLanes-1:0] exp_be    [$];
  vaddr_t              exp_addr  [$];
  vid_t                exp_id    [$];
  int                  exp_row   [$];
  // Number of words up to and including each row
  int                  row_end   [NumRows];

  tb_clock #(.Period(10)) u_tb_clock (.clk_o(clk));

  vldu_top #(
    .NrLanes          (NrLanes),
    .AxiDataWidth     (AxiDataWidth),
    .ResultQueueDepth (2)
  ) u_vldu_top (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_id_i       (req_id),
    .req_vd_i       (req_vd),
    .req_vl_i       (req_vl),
    .req_vsew_i     (req_vsew),
    .ar_valid_i     (ar_valid),
    .ar_len_i       (ar_len),
    .ar_ready_o     (ar_ready),
    .r_valid_i      (r_valid),
    .r_data_i       (r_data),
    .r_ready_o      (r_ready),
    .result_req_o   (result_req),
    .result_id_o    (result_id),
    .result_addr_o  (result_addr),
    .result_wdata_o (result_wdata),
    .result_be_o    (result_be),
    .result_gnt_i   (result_gnt),
    .done_valid_o   (done_valid),
    .done_id_o      (done_id)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // One cycle of a wait loop that samples at the falling edge
  task automatic step_with_timeout(inout int cycles, input string what);
    @(negedge clk);
    cycles++;
    if (cycles > Timeout)
      stop_on_error($sformatf("Timeout after %0d cycles waiting for %s", Timeout, what));
  endtask

  function automatic void set_row(int i, vid_t id, vreg_t vd, vlen_t vl, vsew_e vsew,
                                  int pct);
    rows[i] = '{id, vd, vl, vsew, pct};
  endfunction

  // Element count scaled by element size
  function automatic int row_bytes(int i);
    return int'(rows[i].vl) << int'(rows[i].vsew);
  endfunction

  // Reference packing puts byte j in word j/WordBytes at lane slot j mod WordBytes
  task automatic build_expected();
    int                  nbytes;
    int                  nwords;
    int                  j;
    elen_t [NrLanes-1:0] data;
    strb_t [NrLanes-1:0] be;
    for (int i = 0; i < NumRows; i++) begin
      nbytes = row_bytes(i);
      nwords = (nbytes + WordBytes - 1) / WordBytes;
      for (int w = 0; w < nwords; w++) begin
        data = '0;
        be   = '0;
        for (int l = 0; l < NrLanes; l++) begin
          for (int o = 0; o < 8; o++) begin
            j = w * WordBytes + l * 8 + o;
            // Bytes past the end stay zero and disabled
            if (j < nbytes) begin
              data[l][8*o +: 8] = insn_bytes[i][j];
              be[l][o]          = 1'b1;
            end
          end
        end
        exp_wdata.push_back(data);
        exp_be.push_back(be);
        exp_addr.push_back(vaddr_t'(int'(rows[i].vd) * int'(VRegWords) + w));
        exp_id.push_back(rows[i].id);
        exp_row.push_back(i);
      end
      row_end[i] = exp_id.size();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checking processes
  //////////////////////////////////////////////////////////////////////

  task automatic send_requests();
    int cycles;
    for (int i = 0; i < NumRows; i++) begin
      @(posedge clk);
      #1;
      req_valid = 1'b1;
      req_id    = rows[i].id;
      req_vd    = rows[i].vd;
      req_vl    = rows[i].vl;
      req_vsew  = rows[i].vsew;
      cycles    = 0;
      do
        step_with_timeout(cycles, "req_ready_o");
      while (!req_ready);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    // Four held instructions without data fill the queue
    @(negedge clk);
    check_value("req_ready_o", 64'(req_ready), 64'd0);
    stall_release = 1'b1;
  endtask

  task automatic supply_bursts();
    int                      cycles;
    int                      nbeats;
    logic [AxiDataWidth-1:0] beat;
    for (int i = 0; i < NumRows; i++) begin
      if (i == StallFrom) begin
        // Let the previous beat go and then go quiet
        @(posedge clk);
        #1;
        ar_valid = 1'b0;
        r_valid  = 1'b0;
        cycles   = 0;
        do
          step_with_timeout(cycles, "the four held requests");
        while (!stall_release);
      end
      nbeats = (row_bytes(i) + BeatBytes - 1) / BeatBytes;
      for (int k = 0; k < nbeats; k++) begin
        // Tail bytes of the last beat are random filler
        for (int b = 0; b < BeatBytes; b++)
          beat[8*b +: 8] = insn_bytes[i][k * BeatBytes + b];
        @(posedge clk);
        #1;
        ar_valid = 1'b1;
        ar_len   = beat_len_t'(nbeats - 1);
        r_valid  = 1'b1;
        r_data   = beat;
        cycles   = 0;
        do
          step_with_timeout(cycles, "r_ready_o");
        while (!r_ready);
        // Burst ends with the last beat
        check_value("ar_ready_o", 64'(ar_ready), 64'(k == nbeats - 1));
      end
    end
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
    r_valid  = 1'b0;
  endtask

  task automatic collect_results();
    int   lane_pnt [NrLanes];
    int   total;
    int   done_cnt;
    int   cycles;
    int   w;
    logic all_in;
    total    = exp_id.size();
    lane_pnt = '{default: 0};
    done_cnt = 0;
    cycles   = 0;
    do begin
      @(posedge clk);
      #1;
      // Independent random grant per lane at the rate of the word's row
      for (int l = 0; l < NrLanes; l++) begin
        w = (lane_pnt[l] < total) ? lane_pnt[l] : total - 1;
        result_gnt[l] = ($urandom_range(99) < rows[exp_row[w]].gnt_pct);
      end
      step_with_timeout(cycles, "lane writes and done pulses");
      for (int l = 0; l < NrLanes; l++) begin
        if (result_req[l] && result_gnt[l]) begin
          if (lane_pnt[l] >= total)
            stop_on_error($sformatf("Lane %0d was offered a word after all words", l));
          w = lane_pnt[l];
          check_value($sformatf("result_wdata_o[%0d]", l), result_wdata[l], exp_wdata[w][l]);
          check_value($sformatf("result_be_o[%0d]", l), 64'(result_be[l]), 64'(exp_be[w][l]));
          check_value($sformatf("result_addr_o[%0d]", l), 64'(result_addr[l]),
                      64'(exp_addr[w]));
          check_value($sformatf("result_id_o[%0d]", l), 64'(result_id[l]), 64'(exp_id[w]));
          lane_pnt[l]++;
          cycles = 0;
        end
      end
      if (done_valid) begin
        if (done_cnt >= NumRows)
          stop_on_error("Done pulse with no instruction outstanding");
        check_value("done_id_o", 64'(done_id), 64'(rows[done_cnt].id));
        for (int l = 0; l < NrLanes; l++)
          if (lane_pnt[l] < row_end[done_cnt])
            stop_on_error("Done pulse before every lane wrote the instruction's words");
        done_cnt++;
        cycles = 0;
      end
      all_in = (done_cnt == NumRows);
      for (int l = 0; l < NrLanes; l++)
        all_in = all_in && (lane_pnt[l] == total);
    end while (!all_in);
    @(posedge clk);
    #1;
    result_gnt = '0;
    // Nothing left over once drained
    repeat (4) begin
      @(negedge clk);
      check_value("done_valid_o", 64'(done_valid), 64'd0);
      check_value("result_req_o", 64'(result_req), 64'd0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(Seed));
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req_id        = '0;
    req_vd        = '0;
    req_vl        = '0;
    req_vsew      = EW8;
    ar_valid      = 1'b0;
    ar_len        = '0;
    r_valid       = 1'b0;
    r_data        = '0;
    result_gnt    = '0;
    stall_release = 1'b0;

    // id, vd, vl, element width, lane grant percent
    set_row(0, 3'd1, 5'd2,  16'd8,  EW64, 100);
    set_row(1, 3'd2, 5'd5,  16'd21, EW8,  60);
    set_row(2, 3'd3, 5'd7,  16'd13, EW16, 40);
    set_row(3, 3'd4, 5'd31, 16'd9,  EW32, 25);
    set_row(4, 3'd5, 5'd0,  16'd50, EW16, 70);
    set_row(5, 3'd6, 5'd12, 16'd19, EW8,  50);
    set_row(6, 3'd7, 5'd1,  16'd6,  EW64, 80);
    set_row(7, 3'd0, 5'd3,  16'd7,  EW32, 30);
    set_row(8, 3'd2, 5'd9,  16'd40, EW8,  90);
    set_row(9, 3'd5, 5'd20, 16'd17, EW16, 50);

    for (int i = 0; i < NumRows; i++)
      for (int j = 0; j < MaxBytes; j++)
        insn_bytes[i][j] = 8'($urandom);
    build_expected();

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle outputs right after reset
    @(negedge clk);
    check_value("req_ready_o", 64'(req_ready), 64'd1);
    check_value("r_ready_o", 64'(r_ready), 64'd0);
    check_value("ar_ready_o", 64'(ar_ready), 64'd0);
    check_value("result_req_o", 64'(result_req), 64'd0);
    check_value("done_valid_o", 64'(done_valid), 64'd0);

    fork
      send_requests();
      supply_bursts();
      collect_results();
    join

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/vldu_properties.sv
`default_nettype none

module vldu_properties import vldu_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 r_valid_i,
  input logic                 r_ready_i,
  input logic                 done_valid_i,
  input logic   [NrLanes-1:0] result_req_i,
  input logic   [NrLanes-1:0] result_gnt_i,
  input vid_t   [NrLanes-1:0] result_id_i,
  input vaddr_t [NrLanes-1:0] result_addr_i,
  input elen_t  [NrLanes-1:0] result_wdata_i,
  input strb_t  [NrLanes-1:0] result_be_i
);

  // Read data only taken while offered
  a_r_ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) r_ready_i |-> r_valid_i
  ) else $error("r_ready_o high without r_valid_i");

  // Completion is a single-cycle pulse
  a_done_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_valid_i |=> !done_valid_i
  ) else $error("done_valid_o high for two cycles in a row");

  // Per lane, request and payload hold until that lane grants
  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    a_req_held: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      result_req_i[l] && !result_gnt_i[l] |=>
        result_req_i[l] && $stable(result_id_i[l]) && $stable(result_addr_i[l]) &&
        $stable(result_wdata_i[l]) && $stable(result_be_i[l])
    ) else $error("Lane %0d request dropped or changed before its grant", l);
  end

endmodule

bind vldu_top vldu_properties #(
  .NrLanes (NrLanes)
) u_vldu_properties (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .r_valid_i      (r_valid_i),
  .r_ready_i      (r_ready_o),
  .done_valid_i   (done_valid_o),
  .result_req_i   (result_req_o),
  .result_gnt_i   (result_gnt_i),
  .result_id_i    (result_id_o),
  .result_addr_i  (result_addr_o),
  .result_wdata_i (result_wdata_o),
  .result_be_i    (result_be_o)
);

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int unsigned Period = 10
) (
  output logic clk_o
);

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- design/vldu_top.sv
`default_nettype none

module vldu_top import vldu_pkg::*; #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned AxiDataWidth     = 64,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Sequencer
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  vid_t                    req_id_i,
  input  vreg_t                   req_vd_i,
  input  vlen_t                   req_vl_i,
  input  vsew_e                   req_vsew_i,
  // Address generator
  input  logic                    ar_valid_i,
  input  beat_len_t               ar_len_i,
  output logic                    ar_ready_o,
  // Read data
  input  logic                    r_valid_i,
  input  logic [AxiDataWidth-1:0] r_data_i,
  output logic                    r_ready_o,
  // Lanes
  output logic  [NrLanes-1:0]     result_req_o,
  output vid_t  [NrLanes-1:0]     result_id_o,
  output vaddr_t[NrLanes-1:0]     result_addr_o,
  output elen_t [NrLanes-1:0]     result_wdata_o,
  output strb_t [NrLanes-1:0]     result_be_o,
  input  logic  [NrLanes-1:0]     result_gnt_i,
  // Completion
  output logic                    done_valid_o,
  output vid_t                    done_id_o
);

  issue_if                      issue_bus ();
  word_if #(.NrLanes(NrLanes))  word_bus ();

  vinsn_queue #(
    .NrLanes (NrLanes)
  ) u_vinsn_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_id_i     (req_id_i),
    .req_vd_i     (req_vd_i),
    .req_vl_i     (req_vl_i),
    .req_vsew_i   (req_vsew_i),
    .issue        (issue_bus.queue),
    .commit       (word_bus.monitor),
    .done_valid_o (done_valid_o),
    .done_id_o    (done_id_o)
  );

  beat_unpacker #(
    .NrLanes      (NrLanes),
    .AxiDataWidth (AxiDataWidth)
  ) u_beat_unpacker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_valid_i (ar_valid_i),
    .ar_len_i   (ar_len_i),
    .ar_ready_o (ar_ready_o),
    .r_valid_i  (r_valid_i),
    .r_data_i   (r_data_i),
    .r_ready_o  (r_ready_o),
    .issue      (issue_bus.unpacker),
    .word       (word_bus.producer)
  );

  result_queue #(
    .NrLanes          (NrLanes),
    .ResultQueueDepth (ResultQueueDepth)
  ) u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .word           (word_bus.consumer),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

`default_nettype wire

//--- design/result_queue.sv
`default_nettype none

module result_queue import vldu_pkg::*; #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  word_if.consumer            word,
  // Lane write ports
  output logic  [NrLanes-1:0] result_req_o,
  output vid_t  [NrLanes-1:0] result_id_o,
  output vaddr_t[NrLanes-1:0] result_addr_o,
  output elen_t [NrLanes-1:0] result_wdata_o,
  output strb_t [NrLanes-1:0] result_be_o,
  input  logic  [NrLanes-1:0] result_gnt_i
);

  localparam int unsigned PtrW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);

  // Word storage
  vid_t                id_q    [ResultQueueDepth];
  vaddr_t              addr_q  [ResultQueueDepth];
  elen_t [NrLanes-1:0] wdata_q [ResultQueueDepth];
  strb_t [NrLanes-1:0] be_q    [ResultQueueDepth];

  // Lanes still owing a grant, per entry
  logic [ResultQueueDepth-1:0][NrLanes-1:0] valid_q, valid_d;
  logic [PtrW-1:0]                          wr_pnt_q, rd_pnt_q;
  logic [CntW-1:0]                          cnt_q;
  logic [NrLanes-1:0]                       head_left;

  function automatic logic [PtrW-1:0] pnt_inc(input logic [PtrW-1:0] pnt);
    return (pnt == PtrW'(ResultQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign word.full = (cnt_q == CntW'(ResultQueueDepth));

  // Granted lanes drop out of the head entry
  assign head_left = valid_q[rd_pnt_q] & ~result_gnt_i;
  assign word.pop  = (cnt_q != '0) && (head_left == '0);

  always_comb begin
    valid_d           = valid_q;
    valid_d[rd_pnt_q] = head_left;
    if (word.push)
      valid_d[wr_pnt_q] = '1;
  end

  // Head entry goes to every lane
  assign result_req_o   = valid_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      result_id_o[l]   = id_q[rd_pnt_q];
      result_addr_o[l] = addr_q[rd_pnt_q];
    end
  end

  always_ff @(posedge clk_i) begin
    if (word.push) begin
      id_q[wr_pnt_q]    <= word.id;
      addr_q[wr_pnt_q]  <= word.addr;
      wdata_q[wr_pnt_q] <= word.wdata;
      be_q[wr_pnt_q]    <= word.be;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (word.push)
        wr_pnt_q <= pnt_inc(wr_pnt_q);
      if (word.pop)
        rd_pnt_q <= pnt_inc(rd_pnt_q);
      cnt_q <= cnt_q + CntW'(word.push) - CntW'(word.pop);
    end
  end

endmodule

`default_nettype wire

//--- design/beat_unpacker.sv
`default_nettype none

module beat_unpacker import vldu_pkg::*; #(
  parameter int unsigned NrLanes      = 2,
  parameter int unsigned AxiDataWidth = 64
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Burst info from the address generator
  input  logic                    ar_valid_i,
  input  beat_len_t               ar_len_i,
  output logic                    ar_ready_o,
  // Read data
  input  logic                    r_valid_i,
  input  logic [AxiDataWidth-1:0] r_data_i,
  output logic                    r_ready_o,
  issue_if.unpacker               issue,
  word_if.producer                word
);

  localparam int unsigned BeatBytes = AxiDataWidth / 8;
  localparam int unsigned WordBytes = NrLanes * 8;
  localparam int unsigned RPntW     = $clog2(BeatBytes + 1);
  localparam int unsigned WPntW     = $clog2(WordBytes + 1);

  // Beats taken in the current burst
  beat_len_t                 len_q, len_d;
  // Next unread byte of the beat, next free byte of the word
  logic [RPntW-1:0]          r_pnt_q, r_pnt_d;
  logic [WPntW-1:0]          w_pnt_q, w_pnt_d;
  // Bytes left of the issuing instruction, valid once loaded
  vlen_t                     rem_q, rem_d;
  logic                      loaded_q, loaded_d;
  vaddr_t                    word_idx_q, word_idx_d;
  // Word under assembly
  logic [WordBytes-1:0][7:0] wbuf_q, wbuf_d;
  logic [WordBytes-1:0]      be_q, be_d;

  vlen_t rem_cur, rem_after, take, beat_left, word_left;
  logic  pack;

  assign word.wdata = wbuf_d;
  assign word.be    = be_d;
  assign word.id    = issue.id;
  assign word.addr  = vaddr_t'(issue.vd) * vaddr_t'(VRegWords) + word_idx_q;

  always_comb begin
    int unsigned vb;

    len_d      = len_q;
    r_pnt_d    = r_pnt_q;
    w_pnt_d    = w_pnt_q;
    rem_d      = rem_q;
    loaded_d   = loaded_q;
    word_idx_d = word_idx_q;
    wbuf_d     = wbuf_q;
    be_d       = be_q;
    word.push  = 1'b0;
    issue.done = 1'b0;
    r_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    vb         = 0;

    pack      = r_valid_i && ar_valid_i && issue.valid && !word.full;
    rem_cur   = loaded_q ? rem_q : issue.bytes;
    beat_left = vlen_t'(BeatBytes) - vlen_t'(r_pnt_q);
    word_left = vlen_t'(WordBytes) - vlen_t'(w_pnt_q);

    // Bytes moved this cycle, bounded by word, instruction and beat
    take = (rem_cur < word_left) ? rem_cur : word_left;
    if (beat_left < take)
      take = beat_left;
    rem_after = rem_cur - take;

    if (pack) begin
      // Sequential byte copy, every copied byte enabled
      for (int b = 0; b < BeatBytes; b++) begin
        if (b >= int'(r_pnt_q) && b < int'(r_pnt_q) + int'(take)) begin
          vb         = b - int'(r_pnt_q) + int'(w_pnt_q);
          wbuf_d[vb] = r_data_i[8*b +: 8];
          be_d[vb]   = 1'b1;
        end
      end
      r_pnt_d  = r_pnt_q + RPntW'(take);
      w_pnt_d  = w_pnt_q + WPntW'(take);
      rem_d    = rem_after;
      loaded_d = 1'b1;

      // Word full or instruction out of bytes
      if (w_pnt_d == WPntW'(WordBytes) || rem_after == '0) begin
        word.push  = 1'b1;
        w_pnt_d    = '0;
        word_idx_d = word_idx_q + 1'b1;
      end

      // Beat used up, excess bytes of a last beat are dropped
      if (r_pnt_d == RPntW'(BeatBytes) || rem_after == '0) begin
        r_ready_o = 1'b1;
        r_pnt_d   = '0;
        if (len_q == ar_len_i) begin
          ar_ready_o = 1'b1;
          len_d      = '0;
        end else begin
          len_d = len_q + 1'b1;
        end
      end

      if (rem_after == '0) begin
        issue.done = 1'b1;
        loaded_d   = 1'b0;
        word_idx_d = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_q      <= '0;
      r_pnt_q    <= '0;
      w_pnt_q    <= '0;
      rem_q      <= '0;
      loaded_q   <= 1'b0;
      word_idx_q <= '0;
      wbuf_q     <= '0;
      be_q       <= '0;
    end else begin
      len_q      <= len_d;
      r_pnt_q    <= r_pnt_d;
      w_pnt_q    <= w_pnt_d;
      rem_q      <= rem_d;
      loaded_q   <= loaded_d;
      word_idx_q <= word_idx_d;
      // Fresh zeroed word after a push
      wbuf_q     <= word.push ? '0 : wbuf_d;
      be_q       <= word.push ? '0 : be_d;
    end
  end

endmodule

`default_nettype wire

//--- design/vinsn_queue.sv
`default_nettype none

module vinsn_queue import vldu_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Sequencer requests
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  vid_t       req_id_i,
  input  vreg_t      req_vd_i,
  input  vlen_t      req_vl_i,
  input  vsew_e      req_vsew_i,
  // Unpacker and result queue
  issue_if.queue     issue,
  word_if.monitor    commit,
  // Completion
  output logic       done_valid_o,
  output vid_t       done_id_o
);

  localparam int unsigned WordBytes = NrLanes * 8;
  localparam int unsigned PtrW      = $clog2(VInsnQueueDepth);
  localparam int unsigned CntW      = PtrW + 1;

  // Instruction storage
  vid_t  id_q    [VInsnQueueDepth];
  vreg_t vd_q    [VInsnQueueDepth];
  vlen_t bytes_q [VInsnQueueDepth];

  // Phase pointers, wrap naturally with a power-of-two depth
  logic [PtrW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting to issue and to commit
  logic [CntW-1:0] issue_cnt_q, issue_cnt_d;
  logic [CntW-1:0] commit_cnt_q, commit_cnt_d;
  // Bytes still to be written for the oldest uncommitted instruction
  vlen_t           commit_bytes_q, commit_bytes_d;

  logic  accept;
  logic  commit_valid;
  logic  insn_done;
  vlen_t req_bytes;

  assign req_ready_o  = (commit_cnt_q != CntW'(VInsnQueueDepth));
  assign accept       = req_valid_i && req_ready_o;
  assign commit_valid = (commit_cnt_q != '0);
  assign req_bytes    = vlen_t'(req_vl_i << req_vsew_i);

  // Head of the issue phase
  assign issue.valid = (issue_cnt_q != '0);
  assign issue.id    = id_q[issue_pnt_q];
  assign issue.vd    = vd_q[issue_pnt_q];
  assign issue.bytes = bytes_q[issue_pnt_q];

  always_comb begin
    commit_bytes_d = commit_bytes_q;
    commit_cnt_d   = commit_cnt_q;
    issue_cnt_d    = issue_cnt_q;
    insn_done      = 1'b0;

    // One full word leaves per pop, last word may be partial
    if (commit.pop) begin
      if (commit_bytes_q > vlen_t'(WordBytes))
        commit_bytes_d = commit_bytes_q - vlen_t'(WordBytes);
      else
        commit_bytes_d = '0;
    end

    // Last word of the oldest instruction written
    if (commit_valid && commit.pop && commit_bytes_d == '0) begin
      insn_done    = 1'b1;
      commit_cnt_d = commit_cnt_q - 1'b1;
      // Preload the next one in line
      if (commit_cnt_d != '0)
        commit_bytes_d = bytes_q[commit_pnt_q + 1'b1];
    end

    if (issue.done)
      issue_cnt_d = issue_cnt_q - 1'b1;

    // New instruction, loads the commit count if nothing older is left
    if (accept) begin
      issue_cnt_d = issue_cnt_d + 1'b1;
      if (commit_cnt_d == '0)
        commit_bytes_d = req_bytes;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]    <= req_id_i;
      vd_q[accept_pnt_q]    <= req_vd_i;
      bytes_q[accept_pnt_q] <= req_bytes;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      commit_bytes_q <= '0;
      done_valid_o   <= 1'b0;
      done_id_o      <= '0;
    end else begin
      accept_pnt_q   <= accept_pnt_q + PtrW'(accept);
      issue_pnt_q    <= issue_pnt_q + PtrW'(issue.done);
      commit_pnt_q   <= commit_pnt_q + PtrW'(insn_done);
      issue_cnt_q    <= issue_cnt_d;
      commit_cnt_q   <= commit_cnt_d;
      commit_bytes_q <= commit_bytes_d;
      // Completion goes out one cycle after the last pop
      done_valid_o   <= insn_done;
      done_id_o      <= id_q[commit_pnt_q];
    end
  end

endmodule

`default_nettype wire

//--- design/vldu_if.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Issue channel between instruction queue and beat unpacker
//////////////////////////////////////////////////////////////////////

interface issue_if;

  // Oldest instruction not yet issued
  logic            valid;
  vldu_pkg::vid_t  id;
  vldu_pkg::vreg_t vd;
  vldu_pkg::vlen_t bytes;
  // Pulse when its last byte is packed
  logic            done;

  modport queue (output valid, id, vd, bytes, input done);
  modport unpacker (input valid, id, vd, bytes, output done);

endinterface

//////////////////////////////////////////////////////////////////////
// Word channel into the result queue
//////////////////////////////////////////////////////////////////////

interface word_if #(
  parameter int unsigned NrLanes = 2
);

  // Assembled word, one slice per lane
  logic                           push;
  vldu_pkg::vaddr_t               addr;
  vldu_pkg::vid_t                 id;
  vldu_pkg::elen_t  [NrLanes-1:0] wdata;
  vldu_pkg::strb_t  [NrLanes-1:0] be;
  // Back-pressure
  logic                           full;
  // Head word taken by every lane
  logic                           pop;

  modport producer (output push, addr, id, wdata, be, input full);
  modport consumer (input push, addr, id, wdata, be, output full, pop);
  modport monitor (input pop);

endinterface

`default_nettype wire

//--- design/vldu_pkg.sv
`default_nettype none

package vldu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  // Register-file words per vector register
  localparam int unsigned VRegWords       = 16;
  // In-flight load instructions
  localparam int unsigned VInsnQueueDepth = 4;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // One lane slice of a register-file word and its byte enables
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;

  // Instruction fields
  typedef logic [2:0]  vid_t;
  typedef logic [4:0]  vreg_t;
  // Vector length, also used for byte counts
  typedef logic [15:0] vlen_t;
  // Register-file word address
  typedef logic [11:0] vaddr_t;
  // Burst length minus one
  typedef logic [7:0]  beat_len_t;

  // Element width, byte count is vl shifted left by the code
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

endpackage

`default_nettype wire
